// ==== design/channelRegFile.sv ====
// Terminal count fires on a step with count 0; a same-channel host write or master clear drops the step
`timescale 1ns/100ps
`default_nettype none

module channelRegFile (
  input  wire                                 dma_if,
  input  wire                                 arstN,
  dmaRegBusIf.chanSide                        bus,
  input  wire                                 stepGo,
  input  wire [dmaPkg::chanIdxWidth-1:0]      stepChannel,
  output logic [dmaPkg::wordWidth-1:0]        memAddr,
  output logic                                xferAck,
  output logic                                tcPulse,
  output logic [dmaPkg::chanIdxWidth-1:0]     tcChan
);

  logic [dmaPkg::wordWidth-1:0] baseAddr  [dmaPkg::numChannels];
  logic [dmaPkg::wordWidth-1:0] curAddr   [dmaPkg::numChannels];
  logic [dmaPkg::wordWidth-1:0] baseCount [dmaPkg::numChannels];
  logic [dmaPkg::wordWidth-1:0] curCount  [dmaPkg::numChannels];
  logic [dmaPkg::modeWidth-1:0] mode      [dmaPkg::numChannels];

  logic                         hostHit;
  logic                         stepTake;
  logic                         countZero;
  logic                         autoInit;
  logic                         decrement;
  logic [dmaPkg::wordWidth-1:0] selWord;

  // Host write aimed at the stepping channel wins the edge
  always_comb
  begin
    hostHit = bus.masterClear;
    if (bus.wrStrobe)
    begin
      if ((bus.op == dmaPkg::opChanAddr || bus.op == dmaPkg::opChanCount) &&
          bus.chan == stepChannel)
      begin
        hostHit = 1'b1;
      end
      if (bus.op == dmaPkg::opMode && bus.wrData[dmaPkg::chanIdxWidth-1:0] == stepChannel)
      begin
        hostHit = 1'b1;
      end
    end
  end

  assign stepTake  = stepGo && !hostHit;
  assign countZero = (curCount[stepChannel] == '0);
  assign autoInit  = mode[stepChannel][dmaPkg::modeAutoInitBit];
  assign decrement = mode[stepChannel][dmaPkg::modeDecrementBit];

  always_ff @(posedge dma_if or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < dmaPkg::numChannels; i++)
      begin
        baseAddr[i]  <= '0;
        curAddr[i]   <= '0;
        baseCount[i] <= '0;
        curCount[i]  <= '0;
        mode[i]      <= '0;
      end
      memAddr <= '0;
      xferAck <= 1'b0;
      tcPulse <= 1'b0;
      tcChan  <= '0;
    end
    else if (bus.masterClear)
    begin
      for (int i = 0; i < dmaPkg::numChannels; i++)
      begin
        baseAddr[i]  <= '0;
        curAddr[i]   <= '0;
        baseCount[i] <= '0;
        curCount[i]  <= '0;
        mode[i]      <= '0;
      end
      memAddr <= '0;
      xferAck <= 1'b0;
      tcPulse <= 1'b0;
      tcChan  <= '0;
    end
    else
    begin
      xferAck <= stepTake;
      tcPulse <= stepTake && countZero;

      if (stepTake)
      begin
        // Present the address from before the step
        memAddr <= curAddr[stepChannel];
        tcChan  <= stepChannel;
        if (!countZero)
        begin
          curAddr[stepChannel]  <= decrement ? curAddr[stepChannel] - 1'b1 :
                                               curAddr[stepChannel] + 1'b1;
          curCount[stepChannel] <= curCount[stepChannel] - 1'b1;
        end
        else if (autoInit)
        begin
          curAddr[stepChannel]  <= baseAddr[stepChannel];
          curCount[stepChannel] <= baseCount[stepChannel];
        end
        else
        begin
          curAddr[stepChannel]  <= '0;
          curCount[stepChannel] <= '0;
        end
      end

      // Byte writes load base and current copies together
      if (bus.wrStrobe)
      begin
        case (bus.op)
          dmaPkg::opChanAddr:
          begin
            if (bus.hiByte)
            begin
              baseAddr[bus.chan][dmaPkg::wordWidth-1:dmaPkg::byteWidth] <= bus.wrData;
              curAddr[bus.chan][dmaPkg::wordWidth-1:dmaPkg::byteWidth]  <= bus.wrData;
            end
            else
            begin
              baseAddr[bus.chan][dmaPkg::byteWidth-1:0] <= bus.wrData;
              curAddr[bus.chan][dmaPkg::byteWidth-1:0]  <= bus.wrData;
            end
          end
          dmaPkg::opChanCount:
          begin
            if (bus.hiByte)
            begin
              baseCount[bus.chan][dmaPkg::wordWidth-1:dmaPkg::byteWidth] <= bus.wrData;
              curCount[bus.chan][dmaPkg::wordWidth-1:dmaPkg::byteWidth]  <= bus.wrData;
            end
            else
            begin
              baseCount[bus.chan][dmaPkg::byteWidth-1:0] <= bus.wrData;
              curCount[bus.chan][dmaPkg::byteWidth-1:0]  <= bus.wrData;
            end
          end
          dmaPkg::opMode:
          begin
            // Channel select sits in the two low data bits
            mode[bus.wrData[dmaPkg::chanIdxWidth-1:0]] <=
              bus.wrData[dmaPkg::byteWidth-1:dmaPkg::byteWidth-dmaPkg::modeWidth];
          end
          default:
          begin
          end
        endcase
      end
    end
  end

  // Read back selected byte of the current register
  always_comb
  begin
    selWord = (bus.op == dmaPkg::opChanCount) ? curCount[bus.chan] : curAddr[bus.chan];
    bus.chanRdData = bus.hiByte ? selWord[dmaPkg::wordWidth-1:dmaPkg::byteWidth] :
                                  selWord[dmaPkg::byteWidth-1:0];
  end

  assert property (@(posedge dma_if) disable iff (!arstN) tcPulse |-> xferAck)
    else $error("channelRegFile: tcPulse without xferAck");

  // An acknowledge always traces back to a gated step one edge earlier
  assert property (@(posedge dma_if) disable iff (!arstN) !stepGo |=> !xferAck)
    else $error("channelRegFile: xferAck without a preceding stepGo");

endmodule

`default_nettype wire

// ==== design/controlRegs.sv ====
// Status read clears TC flags after capture; master clear zeroes command, request and mask
`timescale 1ns/100ps
`default_nettype none

module controlRegs (
  input  wire                                 dma_if,
  input  wire                                 arstN,
  dmaRegBusIf.ctrlSide                        bus,
  input  wire                                 xferStep,
  input  wire [dmaPkg::chanIdxWidth-1:0]      stepChannel,
  output logic                                stepGo,
  input  wire                                 tcPulse,
  input  wire [dmaPkg::chanIdxWidth-1:0]      tcChan
);

  logic [dmaPkg::byteWidth-1:0]   command;
  logic [dmaPkg::numChannels-1:0] request;
  logic [dmaPkg::numChannels-1:0] mask;
  logic [dmaPkg::numChannels-1:0] tcFlags;
  logic [dmaPkg::numChannels-1:0] tcSet;
  logic                           statusRead;

  assign statusRead = bus.rdStrobe && (bus.op == dmaPkg::opCommandStatus);

  always_comb
  begin
    tcSet = '0;
    if (tcPulse)
    begin
      tcSet[tcChan] = 1'b1;
    end
  end

  // Steps pass only for an unmasked channel on an enabled controller
  assign stepGo = xferStep && !mask[stepChannel] && !command[dmaPkg::cmdDisableBit];

  // Status is request bits over TC flags
  assign bus.ctrlRdData = (bus.op == dmaPkg::opCommandStatus) ? {request, tcFlags} : '0;

  always_ff @(posedge dma_if or negedge arstN)
  begin
    if (!arstN)
    begin
      command <= '0;
      request <= '0;
      mask    <= '0;
      tcFlags <= '0;
    end
    else if (bus.masterClear)
    begin
      command <= '0;
      request <= '0;
      mask    <= '0;
      tcFlags <= '0;
    end
    else
    begin
      // New TC still lands on the edge of a status read
      tcFlags <= (statusRead ? '0 : tcFlags) | tcSet;

      if (bus.wrStrobe)
      begin
        case (bus.op)
          dmaPkg::opCommandStatus: command <= bus.wrData;
          dmaPkg::opRequest:       request[bus.wrData[dmaPkg::chanIdxWidth-1:0]] <= bus.wrData[2];
          dmaPkg::opSingleMask:    mask[bus.wrData[dmaPkg::chanIdxWidth-1:0]] <= bus.wrData[2];
          dmaPkg::opAllMask:       mask <= bus.wrData[dmaPkg::numChannels-1:0];
          dmaPkg::opClearMask:     mask <= '0;
          default:
          begin
          end
        endcase
      end
    end
  end

  // A channel masked at one edge cannot pass a step in the next cycle
  assert property (@(posedge dma_if) disable iff (!arstN)
    (bus.wrStrobe && bus.op == dmaPkg::opSingleMask && bus.wrData[2]) |=>
      !(stepGo && stepChannel == $past(bus.wrData[dmaPkg::chanIdxWidth-1:0])))
    else $error("controlRegs: step passed for a masked channel");

endmodule

`default_nettype wire

// ==== design/dmaDatapath.sv ====
// Separate host data in and out ports replace the 8237 tri-state bus; no temp register
`timescale 1ns/100ps
`default_nettype none

module dmaDatapath (
  input  wire                                 dma_if,
  input  wire                                 arstN,

  // Host register port
  input  wire                                 csN,
  input  wire                                 iorN,
  input  wire                                 iowN,
  input  wire [dmaPkg::hostAddrWidth-1:0]     addr,
  input  wire [dmaPkg::byteWidth-1:0]         dataIn,
  output logic [dmaPkg::byteWidth-1:0]        dataOut,

  // Transfer step port
  input  wire                                 xferStep,
  input  wire [dmaPkg::chanIdxWidth-1:0]      stepChannel,
  output logic [dmaPkg::wordWidth-1:0]        memAddr,
  output logic                                xferAck,
  output logic                                tc
);

  logic                            stepGo;
  logic [dmaPkg::chanIdxWidth-1:0] tcChan;

  dmaRegBusIf regBus ();

  hostDecoder uHostDecoder (
    .dma_if  (dma_if),
    .arstN   (arstN),
    .csN     (csN),
    .iorN    (iorN),
    .iowN    (iowN),
    .addr    (addr),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .bus     (regBus)
  );

  channelRegFile uChannelRegFile (
    .dma_if      (dma_if),
    .arstN       (arstN),
    .bus         (regBus),
    .stepGo      (stepGo),
    .stepChannel (stepChannel),
    .memAddr     (memAddr),
    .xferAck     (xferAck),
    .tcPulse     (tc),
    .tcChan      (tcChan)
  );

  // TC pulse also feeds the sticky status flags
  controlRegs uControlRegs (
    .dma_if      (dma_if),
    .arstN       (arstN),
    .bus         (regBus),
    .xferStep    (xferStep),
    .stepChannel (stepChannel),
    .stepGo      (stepGo),
    .tcPulse     (tc),
    .tcChan      (tcChan)
  );

endmodule

`default_nettype wire

// ==== design/dmaPkg.sv ====
// Sizes assume four channels of 16-bit registers over an 8-bit host bus
`default_nettype none

package dmaPkg;

  // Channel and bus sizes
  localparam int numChannels   = 4;
  localparam int chanIdxWidth  = 2;
  localparam int byteWidth     = 8;
  localparam int wordWidth     = 16;
  localparam int hostAddrWidth = 4;

  // Stored mode field holds data bits 7..2 of a mode write
  localparam int modeWidth        = 6;
  localparam int modeAutoInitBit  = 2;
  localparam int modeDecrementBit = 3;

  // Command register
  localparam int cmdDisableBit = 2;

  // Host register operations, one per decoded address group
  typedef enum logic [3:0] {
    opNone,
    opChanAddr,
    opChanCount,
    opCommandStatus,
    opRequest,
    opSingleMask,
    opMode,
    opClearBytePtr,
    opMasterClear,
    opClearMask,
    opAllMask
  } regOpT;

endpackage

`default_nettype wire

// ==== design/dmaRegBusIf.sv ====
// Carries one decoded host access per cycle; read data returns combinationally
`timescale 1ns/100ps
`default_nettype none

interface dmaRegBusIf;

  // Decoded access, valid for the cycle after the host strobe
  dmaPkg::regOpT                     op;
  logic                              wrStrobe;
  logic                              rdStrobe;
  logic [dmaPkg::chanIdxWidth-1:0]   chan;
  logic                              hiByte;
  logic [dmaPkg::byteWidth-1:0]      wrData;
  logic                              masterClear;

  // Read data from the register blocks
  logic [dmaPkg::byteWidth-1:0]      chanRdData;
  logic [dmaPkg::byteWidth-1:0]      ctrlRdData;

  modport decoder (
    output op, wrStrobe, rdStrobe, chan, hiByte, wrData, masterClear,
    input  chanRdData, ctrlRdData
  );

  modport chanSide (
    input  op, wrStrobe, rdStrobe, chan, hiByte, wrData, masterClear,
    output chanRdData
  );

  modport ctrlSide (
    input  op, wrStrobe, rdStrobe, chan, hiByte, wrData, masterClear,
    output ctrlRdData
  );

endinterface

`default_nettype wire

// ==== design/hostDecoder.sv ====
// Host pins are synchronous to dma_if; both strobes low is ignored and dataOut holds between reads
`timescale 1ns/100ps
`default_nettype none

module hostDecoder (
  input  wire                                 dma_if,
  input  wire                                 arstN,
  input  wire                                 csN,
  input  wire                                 iorN,
  input  wire                                 iowN,
  input  wire [dmaPkg::hostAddrWidth-1:0]     addr,
  input  wire [dmaPkg::byteWidth-1:0]         dataIn,
  output logic [dmaPkg::byteWidth-1:0]        dataOut,
  dmaRegBusIf.decoder                         bus
);

  logic          hostWr;
  logic          hostRd;
  logic          chanAccess;
  logic          bytePtr;
  dmaPkg::regOpT pinOp;

  function automatic dmaPkg::regOpT decodeOp(input logic [dmaPkg::hostAddrWidth-1:0] a);
    dmaPkg::regOpT result;
    if (!a[3])
    begin
      // Even addresses select address registers, odd ones count registers
      result = a[0] ? dmaPkg::opChanCount : dmaPkg::opChanAddr;
    end
    else
    begin
      case (a[2:0])
        3'd0:    result = dmaPkg::opCommandStatus;
        3'd1:    result = dmaPkg::opRequest;
        3'd2:    result = dmaPkg::opSingleMask;
        3'd3:    result = dmaPkg::opMode;
        3'd4:    result = dmaPkg::opClearBytePtr;
        3'd5:    result = dmaPkg::opMasterClear;
        3'd6:    result = dmaPkg::opClearMask;
        default: result = dmaPkg::opAllMask;
      endcase
    end
    return result;
  endfunction

  assign hostWr = !csN && !iowN && iorN;
  assign hostRd = !csN && !iorN && iowN;

  always_comb
  begin
    pinOp = decodeOp(addr);
  end

  assign chanAccess = (hostWr || hostRd) &&
                      (pinOp == dmaPkg::opChanAddr || pinOp == dmaPkg::opChanCount);

  // Access strobes, byte pointer and registered read data
  always_ff @(posedge dma_if or negedge arstN)
  begin
    if (!arstN)
    begin
      bus.op          <= dmaPkg::opNone;
      bus.wrStrobe    <= 1'b0;
      bus.rdStrobe    <= 1'b0;
      bus.masterClear <= 1'b0;
      bytePtr         <= 1'b0;
      dataOut         <= '0;
    end
    else
    begin
      bus.op          <= (hostWr || hostRd) ? pinOp : dmaPkg::opNone;
      bus.wrStrobe    <= hostWr;
      bus.rdStrobe    <= hostRd;
      bus.masterClear <= hostWr && (pinOp == dmaPkg::opMasterClear);

      if (hostWr && (pinOp == dmaPkg::opClearBytePtr || pinOp == dmaPkg::opMasterClear))
      begin
        bytePtr <= 1'b0;
      end
      else if (chanAccess)
      begin
        bytePtr <= ~bytePtr;
      end

      // Channel reads come from the register file, the rest from control
      if (bus.rdStrobe)
      begin
        dataOut <= (bus.op == dmaPkg::opChanAddr || bus.op == dmaPkg::opChanCount) ?
                   bus.chanRdData : bus.ctrlRdData;
      end
    end
  end

  // Access payload, only meaningful alongside a strobe
  always_ff @(posedge dma_if)
  begin
    bus.chan   <= addr[dmaPkg::chanIdxWidth:1];
    bus.hiByte <= bytePtr;
    bus.wrData <= dataIn;
  end

  // Host must never drive both strobes in one selected cycle
  assert property (@(posedge dma_if) disable iff (!arstN) !csN |-> (iorN || iowN))
    else $error("hostDecoder: iorN and iowN low together while selected");

endmodule

`default_nettype wire

// ==== dmaDatapath.f ====
+incdir+tests
design/dmaPkg.sv
design/dmaRegBusIf.sv
design/hostDecoder.sv
design/channelRegFile.sv
design/controlRegs.sv
design/dmaDatapath.sv
tests/dmaDatapathTb.sv

// ==== tests/dmaModel.svh ====
// Host-visible register model; valid only while host accesses and steps never share a cycle
logic [dmaPkg::wordWidth-1:0]   mBaseAddr  [dmaPkg::numChannels];
logic [dmaPkg::wordWidth-1:0]   mCurAddr   [dmaPkg::numChannels];
logic [dmaPkg::wordWidth-1:0]   mBaseCount [dmaPkg::numChannels];
logic [dmaPkg::wordWidth-1:0]   mCurCount  [dmaPkg::numChannels];
logic [dmaPkg::wordWidth-1:0]   mMemAddr;
logic [dmaPkg::numChannels-1:0] mAutoInit;
logic [dmaPkg::numChannels-1:0] mDecrement;
logic [dmaPkg::numChannels-1:0] mRequest;
logic [dmaPkg::numChannels-1:0] mMask;
logic [dmaPkg::numChannels-1:0] mTcFlags;
logic                           mDisable;
logic                           mBytePtr;

task automatic modelReset();
  for (int i = 0; i < dmaPkg::numChannels; i++)
  begin
    mBaseAddr[i]  = '0;
    mCurAddr[i]   = '0;
    mBaseCount[i] = '0;
    mCurCount[i]  = '0;
  end
  mMemAddr   = '0;
  mAutoInit  = '0;
  mDecrement = '0;
  mRequest   = '0;
  mMask      = '0;
  mTcFlags   = '0;
  mDisable   = 1'b0;
  mBytePtr   = 1'b0;
endtask

function automatic logic [15:0] putByte(input logic [15:0] w, input logic hi, input logic [7:0] b);
  return hi ? {b, w[7:0]} : {w[15:8], b};
endfunction

task automatic modelWrite(input logic [3:0] a, input logic [7:0] d);
  logic [1:0] ch;
  logic [1:0] sel;
  ch = a[2:1];
  sel = d[1:0];
  if (!a[3])
  begin
    // Both base and current copies take the byte
    if (a[0])
    begin
      mBaseCount[ch] = putByte(mBaseCount[ch], mBytePtr, d);
      mCurCount[ch]  = putByte(mCurCount[ch], mBytePtr, d);
    end
    else
    begin
      mBaseAddr[ch] = putByte(mBaseAddr[ch], mBytePtr, d);
      mCurAddr[ch]  = putByte(mCurAddr[ch], mBytePtr, d);
    end
    mBytePtr = ~mBytePtr;
  end
  else
  begin
    case (a[2:0])
      3'd0: mDisable = d[2];
      3'd1: mRequest[sel] = d[2];
      3'd2: mMask[sel] = d[2];
      3'd3:
      begin
        // Auto-init from data bit 4, decrement from bit 5
        mAutoInit[sel]  = d[4];
        mDecrement[sel] = d[5];
      end
      3'd4: mBytePtr = 1'b0;
      3'd5: modelReset();
      3'd6: mMask = '0;
      default: mMask = d[3:0];
    endcase
  end
endtask

task automatic modelRead(input logic [3:0] a, output logic [7:0] expected);
  logic [15:0] w;
  expected = '0;
  if (!a[3])
  begin
    w = a[0] ? mCurCount[a[2:1]] : mCurAddr[a[2:1]];
    expected = mBytePtr ? w[15:8] : w[7:0];
    mBytePtr = ~mBytePtr;
  end
  else if (a[2:0] == 3'd0)
  begin
    expected = {mRequest, mTcFlags};
    mTcFlags = '0;
  end
endtask

task automatic modelStep(input logic [1:0] ch, output logic ack, output logic tcOut);
  ack = !mMask[ch] && !mDisable;
  tcOut = 1'b0;
  if (ack)
  begin
    mMemAddr = mCurAddr[ch];
    if (mCurCount[ch] != 0)
    begin
      mCurAddr[ch]  = mDecrement[ch] ? mCurAddr[ch] - 16'd1 : mCurAddr[ch] + 16'd1;
      mCurCount[ch] = mCurCount[ch] - 16'd1;
    end
    else
    begin
      tcOut = 1'b1;
      mTcFlags[ch] = 1'b1;
      mCurAddr[ch]  = mAutoInit[ch] ? mBaseAddr[ch] : '0;
      mCurCount[ch] = mAutoInit[ch] ? mBaseCount[ch] : '0;
    end
  end
endtask

// ==== tests/dmaDatapathTb.sv ====
// Random host accesses and steps from a fixed seed; each access is one strobe cycle then idle
`timescale 1ns/100ps
`default_nettype none

module dmaDatapathTb;

  localparam int numOps = 2400;
  // At most three cycles per operation, plus margin for reset and the final sweep
  localparam int cycleLimit = numOps * 4 + 400;

  logic        dma_if;
  logic        arstN;
  logic        csN;
  logic        iorN;
  logic        iowN;
  logic [3:0]  addr;
  logic [7:0]  dataIn;
  logic        xferStep;
  logic [1:0]  stepChannel;
  wire  [7:0]  dataOut;
  wire  [15:0] memAddr;
  wire         xferAck;
  wire         tc;
  int          cycleCount = 0;

  `include "dmaModel.svh"

  dmaDatapath uut (
    .dma_if      (dma_if),
    .arstN       (arstN),
    .csN         (csN),
    .iorN        (iorN),
    .iowN        (iowN),
    .addr        (addr),
    .dataIn      (dataIn),
    .dataOut     (dataOut),
    .xferStep    (xferStep),
    .stepChannel (stepChannel),
    .memAddr     (memAddr),
    .xferAck     (xferAck),
    .tc          (tc)
  );

  initial
  begin
    dma_if = 1'b0;
  end

  always #50 dma_if = ~dma_if;

  always @(posedge dma_if)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout: the run went past %0d clock cycles", cycleLimit);
      $display("Finished with errors");
      $fatal(1, "Timeout");
    end
  end

  task automatic checkValue(input string name, input logic [15:0] got,
                            input logic [15:0] expected);
    if (got !== expected)
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      $display("Finished with errors");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic hostWrite(input logic [3:0] a, input logic [7:0] d);
    @(posedge dma_if);
    csN    <= 1'b0;
    iowN   <= 1'b0;
    addr   <= a;
    dataIn <= d;
    @(posedge dma_if);
    csN  <= 1'b1;
    iowN <= 1'b1;
    modelWrite(a, d);
  endtask

  // dataOut loads two edges after the strobe is driven
  task automatic hostRead(input logic [3:0] a);
    logic [7:0] expected;
    @(posedge dma_if);
    csN  <= 1'b0;
    iorN <= 1'b0;
    addr <= a;
    @(posedge dma_if);
    csN  <= 1'b1;
    iorN <= 1'b1;
    @(posedge dma_if);
    @(negedge dma_if);
    modelRead(a, expected);
    checkValue("dataOut", dataOut, expected);
  endtask

  task automatic issueStep(input logic [1:0] ch);
    logic expAck;
    logic expTc;
    @(posedge dma_if);
    xferStep    <= 1'b1;
    stepChannel <= ch;
    @(posedge dma_if);
    xferStep <= 1'b0;
    @(negedge dma_if);
    modelStep(ch, expAck, expTc);
    checkValue("xferAck", xferAck, expAck);
    checkValue("tc", tc, expTc);
    checkValue("memAddr", memAddr, mMemAddr);
  endtask

  // Weighted pick of one host operation or step
  task automatic randomOp();
    int         pick;
    logic [1:0] ch;
    logic       isCount;
    logic [7:0] d;
    pick = $urandom_range(0, 99);
    ch = $urandom_range(0, 3);
    isCount = $urandom_range(0, 1);
    d = $urandom_range(0, 255);
    if (pick < 25)
    begin
      // Mostly small counts so terminal count comes up often
      if (isCount && $urandom_range(0, 3) != 0)
        d = $urandom_range(0, 2);
      hostWrite({1'b0, ch, isCount}, d);
    end
    else if (pick < 45)
      hostRead({1'b0, ch, isCount});
    else if (pick < 50)
      hostWrite(4'd12, d);
    else if (pick < 55)
      hostWrite(4'd11, d);
    else if (pick < 80)
      issueStep(ch);
    else if (pick < 85)
      hostRead(4'd8);
    else if (pick < 88)
      hostWrite(4'd9, d);
    else if (pick < 92)
      hostWrite(4'd10, d);
    else if (pick < 94)
      hostWrite(4'd15, d);
    else if (pick < 96)
      hostWrite(4'd14, d);
    else if (pick < 99)
      hostWrite(4'd8, d);
    else
      hostWrite(4'd13, d);
  endtask

  // Master clear zeroes every register and leaves all channels unmasked
  task automatic clearSweep();
    hostWrite(4'd13, 8'h00);
    for (int ch = 0; ch < dmaPkg::numChannels; ch++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        hostRead({1'b0, ch[1:0], r[1]});
      end
    end
    hostRead(4'd8);
    for (int ch = 0; ch < dmaPkg::numChannels; ch++)
    begin
      issueStep(ch[1:0]);
    end
  endtask

  initial
  begin
    arstN       = 1'b0;
    csN         = 1'b1;
    iorN        = 1'b1;
    iowN        = 1'b1;
    addr        = '0;
    dataIn      = '0;
    xferStep    = 1'b0;
    stepChannel = '0;
    void'($urandom(37966));
    modelReset();
    repeat (4) @(posedge dma_if);
    arstN <= 1'b1;
    for (int i = 0; i < numOps; i++)
    begin
      randomOp();
    end
    clearSweep();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
